/* design/isaPkg.sv */
/*
   isaPkg: word width, register index, opcodes and field layout of the
   16-bit ISA, with small helpers that slice an instruction word.
*/
package isaPkg;

   localparam int WORD_BITS = 16;

   typedef logic [2:0] regIdx_t;

   // Opcode lives in bits 15..11; unlisted codes behave as NOP.
   typedef enum logic [4:0] {
      OP_NOP  = 5'b00000,
      OP_ADD  = 5'b00001,
      OP_ADDI = 5'b00010,
      OP_LD   = 5'b00011,
      OP_ST   = 5'b00100,
      OP_J    = 5'b00101,
      OP_HALT = 5'b11111
   } opcode_e;

   localparam int OP_LSB    = 11;
   localparam int RS_LSB    = 8;
   localparam int RT_LSB    = 5;
   localparam int RD_LSB    = 2;
   localparam int JOFF_BITS = 11;

   function automatic opcode_e opOf(input logic [WORD_BITS-1:0] instr);
      return opcode_e'(instr[OP_LSB +: 5]);
   endfunction

   function automatic regIdx_t rsOf(input logic [WORD_BITS-1:0] instr);
      return instr[RS_LSB +: 3];
   endfunction

   function automatic regIdx_t rtOf(input logic [WORD_BITS-1:0] instr);
      return instr[RT_LSB +: 3];
   endfunction

   function automatic regIdx_t rdOf(input logic [WORD_BITS-1:0] instr);
      return instr[RD_LSB +: 3];
   endfunction

   // Signed word offset of a jump.
   function automatic logic [JOFF_BITS-1:0] jOffOf(input logic [WORD_BITS-1:0] instr);
      return instr[JOFF_BITS-1:0];
   endfunction

endpackage

/* design/pipePkg.sv */
/*
   pipePkg: slot records that move between the fetch, decode and the
   X/M/W stages of the front end.
*/
package pipePkg;

   import isaPkg::*;

   // Raw fetched word as it enters IF/ID.
   typedef struct packed {
      logic                 valid;
      logic [WORD_BITS-1:0] pc;
      logic [WORD_BITS-1:0] instr;
   } fetchSlot_t;

   // Decoded slot carried through X, M and W.
   typedef struct packed {
      logic                 valid;
      logic [WORD_BITS-1:0] pc;
      logic [WORD_BITS-1:0] instr;
      logic                 regWrt;
      regIdx_t              wrtReg;
      logic                 isLoad;
      logic                 isJump;
      logic                 isHalt;
      logic [WORD_BITS-1:0] jumpTarget;
      // EX to EX forwarding.
      logic                 x2xA;
      logic                 x2xB;
      // MEM to EX forwarding.
      logic                 m2xA;
      logic                 m2xB;
   } stageSlot_t;

endpackage

/* design/instrMem.sv */
/*
   instrMem: word-wide instruction memory. Reads are combinational from a
   byte address, writes come in through the load port on a clock edge.
*/
`timescale 1ns/1ps
`default_nettype none
module instrMem
   import isaPkg::*;
#(
   parameter int MEM_WORDS = 256
) (
   input  wire logic                         clk,
   input  wire logic                         loadEn,
   input  wire logic [$clog2(MEM_WORDS)-1:0] loadAddr,
   input  wire logic [WORD_BITS-1:0]         loadData,
   input  wire logic [WORD_BITS-1:0]         addr,
   output logic      [WORD_BITS-1:0]         rdata
);

   localparam int ADDR_BITS = $clog2(MEM_WORDS);

   logic [WORD_BITS-1:0] mem [MEM_WORDS];

   // Load port, used by the testbench while fetch is idle.
   always_ff @(posedge clk) begin
      if (loadEn) begin
         mem[loadAddr] <= loadData;
      end
   end

   // Byte address to word index; range is checked by the fetch stage.
   assign rdata = mem[addr[ADDR_BITS:1]];

endmodule
`default_nettype wire

/* design/fetchStage.sv */
/*
   fetchStage: program counter with +2 step and jump redirect, plus the
   halted and sticky error flags. Reads the instruction memory it owns.
*/
`timescale 1ns/1ps
`default_nettype none
module fetchStage
   import isaPkg::*;
   import pipePkg::*;
#(
   parameter int MEM_WORDS = 256
) (
   input  wire logic                         clk,
   input  wire logic                         rstN,
   input  wire logic                         run,
   input  wire logic                         fetchHold,
   input  wire logic                         haltSeen,
   input  wire logic                         redirect,
   input  wire logic [WORD_BITS-1:0]         redirectPc,
   input  wire logic                         loadEn,
   input  wire logic [$clog2(MEM_WORDS)-1:0] loadAddr,
   input  wire logic [WORD_BITS-1:0]         loadData,
   output fetchSlot_t                        fetchOut,
   output logic                              halted,
   output logic                              err
);

   // First byte address past the end of memory.
   localparam logic [WORD_BITS:0] PC_LIMIT = (WORD_BITS+1)'(2 * MEM_WORDS);

   logic [WORD_BITS-1:0] pc;
   logic [WORD_BITS-1:0] rdata;
   logic [WORD_BITS:0]   pcSum;
   logic                 inRange;
   logic                 fetchActive;
   logic                 fetchValid;
   logic                 fetchBad;

   instrMem #(.MEM_WORDS(MEM_WORDS)) mem (
      .clk(clk),
      .loadEn(loadEn),
      .loadAddr(loadAddr),
      .loadData(loadData),
      .addr(pc),
      .rdata(rdata)
   );

   // Carry out of bit 15 means the increment wrapped past FFFE.
   assign pcSum       = {1'b0, pc} + (WORD_BITS+1)'(2);
   assign inRange     = {1'b0, pc} < PC_LIMIT;
   assign fetchActive = run & ~halted & ~err & ~haltSeen;
   assign fetchValid  = fetchActive & inRange;
   assign fetchBad    = fetchActive & ~fetchHold & ~redirect & (~inRange | pcSum[WORD_BITS]);

   assign fetchOut.valid = fetchValid;
   assign fetchOut.pc    = pc;
   assign fetchOut.instr = rdata;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc     <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         if (haltSeen) begin
            halted <= 1'b1;
         end
         if (fetchBad) begin
            err <= 1'b1;
         end
         // Redirect from W outranks any hold.
         if (redirect) begin
            pc <= redirectPc;
         end else if (fetchValid && !fetchHold && !pcSum[WORD_BITS]) begin
            pc <= pcSum[WORD_BITS-1:0];
         end
      end
   end

endmodule
`default_nettype wire

/* design/pipeReg.sv */
/*
   pipeReg: one stage register for any slot type with a valid bit.
   Squash drops a bubble in, hold keeps the current contents.
*/
`timescale 1ns/1ps
`default_nettype none
module pipeReg
   import pipePkg::*;
#(
   parameter type payload_t = fetchSlot_t
) (
   input  wire logic clk,
   input  wire logic rstN,
   input  wire logic hold,
   input  wire logic squash,
   input  payload_t  d,
   output payload_t  q
);

   // Only the valid bit is cleared; the rest is don't-care in a bubble.
   always_ff @(posedge clk) begin
      if (!rstN || squash) begin
         q.valid <= 1'b0;
      end else if (!hold) begin
         q <= d;
      end
   end

endmodule
`default_nettype wire

/* design/hazardUnit.sv */
/*
   hazardUnit: decodes the IF/ID word, stalls on load-use, holds fetch
   while a jump drains to W, flags halt, and picks forwarding paths.
*/
`timescale 1ns/1ps
`default_nettype none
module hazardUnit
   import isaPkg::*;
   import pipePkg::*;
(
   input  fetchSlot_t           decSlot,
   input  stageSlot_t           xSlot,
   input  stageSlot_t           mSlot,
   input  stageSlot_t           wSlot,
   output stageSlot_t           issueNext,
   output logic                 fetchHold,
   output logic                 ifIdHold,
   output logic                 ifIdSquash,
   output logic                 haltSeen,
   output logic                 redirect,
   output logic [WORD_BITS-1:0] redirectPc
);

   regIdx_t              srcA;
   regIdx_t              srcB;
   regIdx_t              dst;
   logic                 readA;
   logic                 readB;
   logic                 writes;
   logic                 isLoad;
   logic                 isJump;
   logic                 isHalt;
   logic                 loadUse;
   logic                 jumpBusy;
   logic                 x2xA;
   logic                 x2xB;
   logic                 m2xA;
   logic                 m2xB;
   logic [WORD_BITS-1:0] jumpTarget;
   logic [JOFF_BITS-1:0] jOff;

   // True when a real source matches what a valid slot will write.
   function automatic logic hits(input logic used, input regIdx_t src, input stageSlot_t s);
      return used & s.valid & s.regWrt & (src == s.wrtReg);
   endfunction

   always_comb begin
      srcA   = rsOf(decSlot.instr);
      srcB   = rtOf(decSlot.instr);
      dst    = rtOf(decSlot.instr);
      readA  = 1'b0;
      readB  = 1'b0;
      writes = 1'b0;
      isLoad = 1'b0;
      isJump = 1'b0;
      isHalt = 1'b0;
      case (opOf(decSlot.instr))
         OP_ADD: begin
            readA  = 1'b1;
            readB  = 1'b1;
            writes = 1'b1;
            dst    = rdOf(decSlot.instr);
         end
         OP_ADDI: begin
            readA  = 1'b1;
            writes = 1'b1;
         end
         OP_LD: begin
            readA  = 1'b1;
            writes = 1'b1;
            isLoad = 1'b1;
         end
         OP_ST: begin
            readA = 1'b1;
            readB = 1'b1;
         end
         OP_J:    isJump = 1'b1;
         OP_HALT: isHalt = 1'b1;
         default: ;
      endcase
   end

   // Target is pc + 2 + 2 * sign-extended word offset.
   assign jOff       = jOffOf(decSlot.instr);
   assign jumpTarget = decSlot.pc + WORD_BITS'(2) + {{(WORD_BITS-JOFF_BITS-1){jOff[JOFF_BITS-1]}},
                                                     jOff, 1'b0};

   assign loadUse = decSlot.valid & xSlot.isLoad &
                    (hits(readA, srcA, xSlot) | hits(readB, srcB, xSlot));

   // A load result is not ready in X, so only M may forward it.
   assign x2xA = hits(readA, srcA, xSlot) & ~xSlot.isLoad;
   assign x2xB = hits(readB, srcB, xSlot) & ~xSlot.isLoad;
   assign m2xA = hits(readA, srcA, mSlot) & ~x2xA;
   assign m2xB = hits(readB, srcB, mSlot) & ~x2xB;

   assign jumpBusy   = (decSlot.valid & isJump) | (xSlot.valid & xSlot.isJump) |
                       (mSlot.valid & mSlot.isJump);
   assign redirect   = wSlot.valid & wSlot.isJump;
   assign redirectPc = wSlot.jumpTarget;
   assign haltSeen   = decSlot.valid & isHalt;

   assign fetchHold  = loadUse | jumpBusy;
   assign ifIdHold   = loadUse;
   assign ifIdSquash = jumpBusy | redirect | haltSeen;

   always_comb begin
      issueNext.valid      = decSlot.valid & ~loadUse;
      issueNext.pc         = decSlot.pc;
      issueNext.instr      = decSlot.instr;
      issueNext.regWrt     = writes;
      issueNext.wrtReg     = dst;
      issueNext.isLoad     = isLoad;
      issueNext.isJump     = isJump;
      issueNext.isHalt     = isHalt;
      issueNext.jumpTarget = jumpTarget;
      issueNext.x2xA       = x2xA;
      issueNext.x2xB       = x2xB;
      issueNext.m2xA       = m2xA;
      issueNext.m2xB       = m2xB;
   end

endmodule
`default_nettype wire

/* design/frontEnd.sv */
/*
   frontEnd: instruction front end. Fetch feeds IF/ID, the hazard unit
   issues into X, and X/M/W slots feed back for hazards and redirects.
*/
`timescale 1ns/1ps
`default_nettype none
module frontEnd
   import isaPkg::*;
   import pipePkg::*;
#(
   parameter int MEM_WORDS = 256
) (
   input  wire logic                         clk,
   input  wire logic                         rstN,
   input  wire logic                         loadEn,
   input  wire logic [$clog2(MEM_WORDS)-1:0] loadAddr,
   input  wire logic [WORD_BITS-1:0]         loadData,
   input  wire logic                         run,
   output stageSlot_t                        issue,
   output logic                              halted,
   output logic                              err
);

   fetchSlot_t           fetchOut;
   fetchSlot_t           decSlot;
   stageSlot_t           issueNext;
   stageSlot_t           xSlot;
   stageSlot_t           mSlot;
   stageSlot_t           wSlot;
   logic                 fetchHold;
   logic                 ifIdHold;
   logic                 ifIdSquash;
   logic                 haltSeen;
   logic                 redirect;
   logic [WORD_BITS-1:0] redirectPc;

   fetchStage #(.MEM_WORDS(MEM_WORDS)) fetch (
      .clk(clk), .rstN(rstN), .run(run),
      .fetchHold(fetchHold), .haltSeen(haltSeen),
      .redirect(redirect), .redirectPc(redirectPc),
      .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
      .fetchOut(fetchOut), .halted(halted), .err(err)
   );

   pipeReg #(.payload_t(fetchSlot_t)) ifIdReg (
      .clk(clk), .rstN(rstN), .hold(ifIdHold), .squash(ifIdSquash),
      .d(fetchOut), .q(decSlot)
   );

   hazardUnit hazard (
      .decSlot(decSlot), .xSlot(xSlot), .mSlot(mSlot), .wSlot(wSlot),
      .issueNext(issueNext), .fetchHold(fetchHold), .ifIdHold(ifIdHold),
      .ifIdSquash(ifIdSquash), .haltSeen(haltSeen),
      .redirect(redirect), .redirectPc(redirectPc)
   );

   // Later stages never stall; bubbles come from the hazard unit.
   pipeReg #(.payload_t(stageSlot_t)) xReg (
      .clk(clk), .rstN(rstN), .hold(1'b0), .squash(1'b0), .d(issueNext), .q(xSlot)
   );

   pipeReg #(.payload_t(stageSlot_t)) mReg (
      .clk(clk), .rstN(rstN), .hold(1'b0), .squash(1'b0), .d(xSlot), .q(mSlot)
   );

   pipeReg #(.payload_t(stageSlot_t)) wReg (
      .clk(clk), .rstN(rstN), .hold(1'b0), .squash(1'b0), .d(mSlot), .q(wSlot)
   );

   assign issue = xSlot;

endmodule
`default_nettype wire

/* tests/frontEnd_checker.sv */
/*
   frontEnd_checker: concurrent assertions on the issue port and the
   halt and error flags of the front end.
*/
`timescale 1ns/1ps
module frontEnd_checker
   import pipePkg::*;
(
   input logic       clk,
   input logic       rstN,
   input stageSlot_t issue,
   input logic       halted,
   input logic       err
);

   // Once halt has settled or an error is up, nothing more issues.
   stopQuiet: assert property (@(posedge clk) disable iff (!rstN)
      (err || (halted && $past(halted))) |-> !issue.valid)
      else $error("slot issued after halt or error");

   // An operand takes at most one forwarding path.
   fwdExclusive: assert property (@(posedge clk) disable iff (!rstN)
      !(issue.x2xA && issue.m2xA) && !(issue.x2xB && issue.m2xB))
      else $error("both forwarding paths set for one operand");

   // The first reset edge clears the X slot.
   resetEmpty: assert property (@(posedge clk) (!rstN && $past(!rstN)) |-> !issue.valid)
      else $error("slot valid during reset");

endmodule

bind frontEnd frontEnd_checker checker_inst (
   .clk(clk), .rstN(rstN), .issue(issue), .halted(halted), .err(err)
);

/* tests/frontEnd_tb.sv */
/*
   frontEnd testbench: builds random programs from an LFSR, loads them,
   runs the front end and checks every issued slot against a program-order
   model of stalls, jumps and forwarding.
*/
`timescale 1ns/1ps
module frontEnd_tb
   import isaPkg::*;
   import pipePkg::*;
();

   localparam int MEM_WORDS = 256;
   localparam int ADDR_BITS = $clog2(MEM_WORDS);
   localparam int TIMEOUT   = 2000;
   localparam int QUIET     = 8;

   localparam int MODE_ALU = 0;
   localparam int MODE_FWD = 1;
   localparam int MODE_LDU = 2;
   localparam int MODE_ALL = 3;
   localparam int MODE_ERR = 4;

   // Opcode mix per program mode, indexed by three random bits.
   localparam logic [4:0] OP_TABLE [5][8] = '{
      '{OP_NOP, OP_ST, 5'h0a, OP_ADDI, OP_ADDI, OP_ADD, OP_ADD, OP_ADD},
      '{OP_ADD, OP_ADDI, OP_ADD, OP_ADDI, OP_ADD, OP_ADDI, OP_ADD, OP_ADDI},
      '{OP_LD, OP_LD, OP_LD, OP_ADD, OP_ADD, OP_ST, OP_ADDI, OP_ADDI},
      '{OP_NOP, OP_ADD, OP_ADDI, OP_LD, OP_ST, OP_J, OP_ADD, 5'h0c},
      '{OP_NOP, OP_ST, 5'h0a, OP_ADDI, OP_ADDI, OP_ADD, OP_ADD, OP_ADD}
   };

   logic                 clk = 1'b0;
   logic                 rstN;
   logic                 loadEn;
   logic [ADDR_BITS-1:0] loadAddr;
   logic [WORD_BITS-1:0] loadData;
   logic                 run;
   stageSlot_t           issue;
   logic                 halted;
   logic                 err;

   logic [31:0]          lfsr = 32'h65f9f9e1;
   logic [WORD_BITS-1:0] prog [MEM_WORDS];
   stageSlot_t           expSlots [$];
   logic                 expErr;
   int                   errCount = 0;
   int                   checks = 0;
   int                   tests = 0;

   frontEnd #(.MEM_WORDS(MEM_WORDS)) frontEnd_inst (
      .clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr),
      .loadData(loadData), .run(run), .issue(issue), .halted(halted), .err(err)
   );

   always #10 clk = ~clk;

   // Fibonacci LFSR, taps 32, 22, 2 and 1.
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic int randBits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsrNext(lfsr);
         v = (v << 1) | int'(lfsr[0]);
      end
      return v;
   endfunction

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic checkSlot(input string name, input stageSlot_t exp, input stageSlot_t act,
                            input bit withFwd);
      logic [3:0] expFwd;
      logic [3:0] actFwd;
      expFwd = {exp.x2xA, exp.x2xB, exp.m2xA, exp.m2xB};
      actFwd = {act.x2xA, act.x2xB, act.m2xA, act.m2xB};
      checks++;
      if (act.pc !== exp.pc || act.instr !== exp.instr || (withFwd && actFwd !== expFwd)) begin
         errCount++;
         $display("FAIL %s: expected pc %h instr %h fwd %b, actual pc %h instr %h fwd %b",
                  name, exp.pc, exp.instr, expFwd, act.pc, act.instr, actFwd);
      end
   endtask

   task automatic checkFlag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errCount++;
         $display("FAIL %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic resetDut();
      rstN = 1'b0;
      run = 1'b0;
      loadEn = 1'b0;
      repeat (2) tick();
      rstN = 1'b1;
   endtask

   // Jumps only go forward inside the program, except the far one in error mode.
   task automatic genProgram(input int n, input int mode);
      logic [4:0]           op;
      logic [WORD_BITS-1:0] w;
      logic [10:0]          off;
      for (int i = 0; i < n - 1; i++) begin
         op = OP_TABLE[3'(mode)][3'(randBits(3))];
         w = {op, 11'(randBits(11))};
         if (mode == MODE_FWD || mode == MODE_LDU) begin
            w = w & 16'hF927;
         end
         if (op == OP_J) begin
            off = 11'(randBits(4) % (n - 1 - i));
            w = {op, off};
         end
         if (mode == MODE_ERR && i == n / 2) begin
            off = 11'(300 + randBits(8));
            w = {OP_J, off};
         end
         prog[i] = w;
      end
      prog[n - 1] = {OP_HALT, 11'(randBits(11))};
   endtask

   task automatic loadProgram(input int n);
      for (int i = 0; i < n; i++) begin
         loadEn = 1'b1;
         loadAddr = ADDR_BITS'(i);
         loadData = prog[i];
         tick();
      end
      loadEn = 1'b0;
   endtask

   // Walks the program in order; p1 and p2 are the slots one and two ahead.
   task automatic buildExpected();
      logic [WORD_BITS-1:0] pc;
      logic [WORD_BITS-1:0] w;
      logic [WORD_BITS-1:0] target;
      logic [4:0]           op;
      logic                 rdA;
      logic                 rdB;
      stageSlot_t           cur;
      stageSlot_t           p1;
      stageSlot_t           p2;
      bit                   done;
      int                   steps;
      expSlots.delete();
      expErr = 1'b0;
      pc = '0;
      p1 = '0;
      p2 = '0;
      done = 1'b0;
      steps = 0;
      while (!done && steps < MEM_WORDS) begin
         w = prog[pc[ADDR_BITS:1]];
         op = w[15:11];
         rdA = (op == OP_ADD) || (op == OP_ADDI) || (op == OP_LD) || (op == OP_ST);
         rdB = (op == OP_ADD) || (op == OP_ST);
         cur = '0;
         cur.valid = 1'b1;
         cur.pc = pc;
         cur.instr = w;
         cur.regWrt = (op == OP_ADD) || (op == OP_ADDI) || (op == OP_LD);
         cur.wrtReg = (op == OP_ADD) ? w[4:2] : w[7:5];
         cur.isLoad = (op == OP_LD);
         // Load-use inserts one bubble, so the load ends up two ahead.
         if (p1.valid && p1.isLoad &&
             ((rdA && w[10:8] == p1.wrtReg) || (rdB && w[7:5] == p1.wrtReg))) begin
            p2 = p1;
            p1 = '0;
         end
         cur.x2xA = rdA && p1.valid && p1.regWrt && !p1.isLoad && (w[10:8] == p1.wrtReg);
         cur.x2xB = rdB && p1.valid && p1.regWrt && !p1.isLoad && (w[7:5] == p1.wrtReg);
         cur.m2xA = rdA && p2.valid && p2.regWrt && (w[10:8] == p2.wrtReg) && !cur.x2xA;
         cur.m2xB = rdB && p2.valid && p2.regWrt && (w[7:5] == p2.wrtReg) && !cur.x2xB;
         expSlots.push_back(cur);
         p2 = p1;
         p1 = cur;
         if (op == OP_HALT) begin
            done = 1'b1;
         end else if (op == OP_J) begin
            target = pc + 16'd2 + {{4{w[10]}}, w[10:0], 1'b0};
            // The pipeline drains before the target is fetched.
            p1 = '0;
            p2 = '0;
            if (int'(target) >= 2 * MEM_WORDS) begin
               expErr = 1'b1;
               done = 1'b1;
            end
            pc = target;
         end else begin
            pc = pc + 16'd2;
         end
         steps++;
      end
   endtask

   task automatic runTest(input string name, input int mode, input int n, input bit withFwd,
                          input bit toggleRun);
      int errStart;
      int k;
      int cyc;
      errStart = errCount;
      resetDut();
      genProgram(n, mode);
      loadProgram(n);
      buildExpected();
      run = 1'b1;
      k = 0;
      cyc = 0;
      while (!(k >= expSlots.size() && (expErr ? err : halted)) && cyc < TIMEOUT) begin
         tick();
         cyc++;
         if (issue.valid) begin
            if (k < expSlots.size()) begin
               checkSlot(name, expSlots[k], issue, withFwd);
            end else begin
               errCount++;
               $display("%s: slot at pc %h issued past the end of the program", name, issue.pc);
            end
            k++;
         end
         if (toggleRun) begin
            run = (randBits(2) != 0);
         end
      end
      if (cyc >= TIMEOUT) begin
         errCount++;
         $display("%s: timed out after %0d cycles, %0d of %0d slots issued",
                  name, cyc, k, expSlots.size());
      end
      for (int q = 0; q < QUIET; q++) begin
         tick();
         if (issue.valid) begin
            errCount++;
            $display("%s: slot at pc %h issued after fetch stopped", name, issue.pc);
         end
      end
      checkFlag($sformatf("%s halted", name), !expErr, halted);
      checkFlag($sformatf("%s err", name), expErr, err);
      tests++;
      $display("%s: %0d slots issued, %0d errors", name, k, errCount - errStart);
   endtask

   initial begin
      rstN = 1'b0;
      run = 1'b0;
      loadEn = 1'b0;
      loadAddr = '0;
      loadData = '0;
      runTest("straight-line", MODE_ALU, 40, 1'b1, 1'b0);
      runTest("forwarding", MODE_FWD, 40, 1'b1, 1'b0);
      runTest("load-use", MODE_LDU, 40, 1'b1, 1'b0);
      runTest("jumps", MODE_ALL, 48, 1'b1, 1'b0);
      runTest("halt-and-run", MODE_ALL, 48, 1'b0, 1'b1);
      runTest("range-error", MODE_ERR, 32, 1'b1, 1'b0);
      $display("Done: %0d tests, %0d checks, %0d errors", tests, checks, errCount);
      if (errCount == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* tb.f */
design/isaPkg.sv
design/pipePkg.sv
design/instrMem.sv
design/fetchStage.sv
design/pipeReg.sv
design/hazardUnit.sv
design/frontEnd.sv
tests/frontEnd_checker.sv
tests/frontEnd_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the front-end testbench with Verilator; the log decides the result.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module frontEnd_tb -f tb.f -o simv \
   > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
